/* common/jts16b_math_pkg.sv */
// Shared bus struct, compare status union and register map of the math chips.
// Also holds the divider step count, window defaults and the byte-lane merge.
package jts16b_math_pkg;

    typedef struct packed {
        logic        as;    // One-cycle access strobe.
        logic [23:1] addr;  // Word address.
        logic [1:0]  dsn;   // Byte lanes, active low.
        logic        rnw;   // High for a read.
        logic [15:0] din;   // Write data.
    } cpu_bus_t;

    typedef struct packed {
        logic        below; // Value under the low bound.
        logic        above; // Value over the high bound.
        logic [13:0] zero;  // Always read as zero.
    } cmp_flags_t;

    // Status word, seen as flags by the compare logic and raw by the CPU.
    typedef union packed {
        logic [15:0] raw;
        cmp_flags_t  flags;
    } cmp_status_u;

    // 315-5248 multiplier map.
    localparam logic [3:0] mul_a  = 4'd0;
    localparam logic [3:0] mul_b  = 4'd1;
    localparam logic [3:0] mul_hi = 4'd2;
    localparam logic [3:0] mul_lo = 4'd3;

    // 315-5249 divider map.
    localparam logic [3:0] div_num_hi = 4'd0;
    localparam logic [3:0] div_num_lo = 4'd1;
    localparam logic [3:0] div_den    = 4'd2;
    localparam logic [3:0] div_start  = 4'd3;
    localparam logic [3:0] div_stat   = 4'd4;
    localparam logic [3:0] div_q_hi   = 4'd5;
    localparam logic [3:0] div_q_lo   = 4'd6;
    localparam logic [3:0] div_rem    = 4'd7;

    // 315-5250 compare/timer map.
    localparam logic [3:0] cmp_bound1    = 4'd0;
    localparam logic [3:0] cmp_bound2    = 4'd1;
    localparam logic [3:0] cmp_value     = 4'd2;
    localparam logic [3:0] cmp_stat      = 4'd3;
    localparam logic [3:0] cmp_hist      = 4'd4;
    localparam logic [3:0] cmp_value_alt = 4'd6;
    localparam logic [3:0] cmp_clamp     = 4'd7;
    localparam logic [3:0] cmp_sound     = 4'd15;

    localparam int          div_steps = 32;        // One quotient bit per cycle.
    localparam logic [15:0] open_bus  = 16'hFFFF;  // Nothing drives the bus.

    // Default windows, matched against addr[23:12].
    localparam logic [11:0] def_mul_base = 12'hC00;
    localparam logic [11:0] def_div_base = 12'hC01;
    localparam logic [11:0] def_cmp_base = 12'hC02;

    // Keeps the old byte where its lane is not enabled.
    function automatic logic [15:0] lane_merge(input logic [15:0] old_word,
                                               input logic [15:0] din,
                                               input logic [1:0]  dsn);
        lane_merge = {dsn[1] ? old_word[15:8] : din[15:8],
                      dsn[0] ? old_word[7:0]  : din[7:0]};
    endfunction

endpackage

/* source/jts16b_bus_decode.sv */
// Address window decode into unit selects and write strobes.
// Registered read-data mux with open bus for unmapped reads.
module jts16b_bus_decode #(
    parameter logic [11:0] mul_base = jts16b_math_pkg::def_mul_base,
    parameter logic [11:0] div_base = jts16b_math_pkg::def_div_base,
    parameter logic [11:0] cmp_base = jts16b_math_pkg::def_cmp_base
) (
    input  logic                     clk,
    input  logic                     rst,
    input  jts16b_math_pkg::cpu_bus_t bus,
    input  logic [15:0]              mul_dout,
    input  logic [15:0]              div_dout,
    input  logic [15:0]              cmp_dout,
    output logic                     mul_cs,
    output logic                     div_cs,
    output logic                     cmp_cs,
    output logic                     mul_we,
    output logic                     div_we,
    output logic                     cmp_we,
    output logic [3:0]               reg_sel,
    output logic [15:0]              dout
);
    import jts16b_math_pkg::*;

    logic       wr;       // Write with at least one lane.
    logic       rd;       // Any other access.
    logic [2:0] rd_unit;  // One-hot {cmp, div, mul} of the last read.
    logic       rd_open;  // Last read hit no window.

    assign mul_cs  = bus.as && (bus.addr[23:12] == mul_base);
    assign div_cs  = bus.as && (bus.addr[23:12] == div_base);
    assign cmp_cs  = bus.as && (bus.addr[23:12] == cmp_base);
    assign wr      = !bus.rnw && (bus.dsn != 2'b11);
    assign rd      = bus.as && !wr;
    assign mul_we  = mul_cs && wr;
    assign div_we  = div_cs && wr;
    assign cmp_we  = cmp_cs && wr;
    assign reg_sel = bus.addr[4:1];   // Register index inside a window.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_unit <= '0;
            rd_open <= 1'b0;
        end else if (rd) begin
            rd_unit <= {cmp_cs, div_cs, mul_cs};
            rd_open <= !(mul_cs || div_cs || cmp_cs);
        end
    end

    // Units hold their read data, so the mux only needs the target.
    always_comb begin
        dout = '0;                          // No read since reset.
        if (rd_open)         dout = open_bus;
        else if (rd_unit[0]) dout = mul_dout;
        else if (rd_unit[1]) dout = div_dout;
        else if (rd_unit[2]) dout = cmp_dout;
    end

endmodule

/* source/jts16b_multiplier.sv */
// 315-5248 style signed 16x16 multiplier.
// Two byte-lane operand registers and a registered 32-bit product.
module jts16b_multiplier (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  logic        we,
    input  logic [3:0]  reg_sel,
    input  logic [1:0]  dsn,
    input  logic [15:0] din,
    output logic [15:0] dout
);
    import jts16b_math_pkg::*;

    logic signed [15:0] op_a;     // First operand.
    logic signed [15:0] op_b;     // Second operand.
    logic signed [31:0] product;  // Follows the operands by one cycle.
    logic [15:0]        rd_data;

    always_comb begin
        case (reg_sel)
            mul_a:   rd_data = op_a;
            mul_b:   rd_data = op_b;
            mul_hi:  rd_data = product[31:16];
            mul_lo:  rd_data = product[15:0];
            default: rd_data = open_bus;     // Rest of the window is empty.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_a    <= '0;
            op_b    <= '0;
            product <= '0;
            dout    <= '0;
        end else begin
            product <= op_a * op_b;          // Both operands signed.
            if (we) begin
                case (reg_sel)
                    mul_a:   op_a <= lane_merge(op_a, din, dsn);
                    mul_b:   op_b <= lane_merge(op_b, din, dsn);
                    default: ;               // Product words are read only.
                endcase
            end else if (cs) begin
                dout <= rd_data;
            end
        end
    end

endmodule

/* compare/jts16b_timer.sv */
// 315-5250 style compare/timer block.
// Signed clamp with status word, in-range hit history and the sound latch.
module jts16b_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  logic        we,
    input  logic [3:0]  reg_sel,
    input  logic [1:0]  dsn,
    input  logic [15:0] din,
    output logic [15:0] dout,
    output logic        snd_irq,
    output logic [7:0]  snd_data
);
    import jts16b_math_pkg::*;

    logic signed [15:0] bound1;      // Either bound may be the lower one.
    logic signed [15:0] bound2;
    logic signed [15:0] value;
    logic signed [15:0] lo_bound;
    logic signed [15:0] hi_bound;
    logic signed [15:0] clamp;       // Value pulled into the bounds.
    logic signed [15:0] clamp_next;
    cmp_status_u        stat;
    cmp_status_u        stat_next;
    logic [15:0]        hist;        // One bit per value write burst.
    logic [3:0]         hist_ptr;    // Next history bit.
    logic               written;     // Write seen last cycle.
    logic [15:0]        rd_data;

    assign lo_bound = (bound1 < bound2) ? bound1 : bound2;
    assign hi_bound = (bound1 > bound2) ? bound1 : bound2;

    // Below wins when the bounds are crossed by the value on both sides.
    always_comb begin
        stat_next.raw = '0;
        clamp_next    = value;
        if (value < lo_bound) begin
            stat_next.flags.below = 1'b1;    // Reads as 8000.
            clamp_next            = lo_bound;
        end else if (value > hi_bound) begin
            stat_next.flags.above = 1'b1;    // Reads as 4000.
            clamp_next            = hi_bound;
        end
    end

    always_comb begin
        case (reg_sel)
            cmp_bound1:    rd_data = bound1;
            cmp_bound2:    rd_data = bound2;
            cmp_value:     rd_data = value;
            cmp_stat:      rd_data = stat.raw;
            cmp_hist:      rd_data = hist;
            cmp_value_alt: rd_data = value;  // Alias of the value.
            cmp_clamp:     rd_data = clamp;
            default:       rd_data = open_bus;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bound1   <= '0;
            bound2   <= '0;
            value    <= '0;
            clamp    <= '0;
            stat     <= '0;
            hist     <= '0;
            hist_ptr <= '0;
            written  <= 1'b0;
            snd_irq  <= 1'b0;
            snd_data <= '0;
            dout     <= '0;
        end else begin
            clamp   <= clamp_next;           // Tracks bounds and value.
            stat    <= stat_next;
            written <= we;
            if (we) begin
                case (reg_sel)
                    cmp_bound1: bound1 <= lane_merge(bound1, din, dsn);
                    cmp_bound2: bound2 <= lane_merge(bound2, din, dsn);
                    cmp_value: begin
                        value <= lane_merge(value, din, dsn);
                        if (!written) begin
                            // Logs the status before this write.
                            hist[hist_ptr] <= (stat.raw == '0);
                            hist_ptr       <= hist_ptr + 4'd1;
                        end
                    end
                    cmp_hist: begin
                        hist     <= '0;      // Any write clears.
                        hist_ptr <= '0;
                    end
                    cmp_value_alt: value <= lane_merge(value, din, dsn);
                    cmp_sound: begin
                        snd_data <= din[7:0];
                        snd_irq  <= 1'b1;    // No acknowledge, held until reset.
                    end
                    default: ;
                endcase
            end else if (cs) begin
                dout <= rd_data;
            end
        end
    end

endmodule

/* divide/jts16b_divider.sv */
// 315-5249 style unsigned 32/16 divider.
// Operand and result register banks around a restoring shift-subtract engine.
module jts16b_divider (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  logic        we,
    input  logic [3:0]  reg_sel,
    input  logic [1:0]  dsn,
    input  logic [15:0] din,
    output logic [15:0] dout
);
    import jts16b_math_pkg::*;

    localparam int cnt_w = $clog2(div_steps);

    // CPU side operands, free to change while the engine runs.
    logic [31:0]      num;
    logic [15:0]      den;
    // Engine state.
    logic [31:0]      q_work;      // Dividend shifting out, quotient in.
    logic [15:0]      r_work;      // Partial remainder.
    logic [15:0]      d_work;      // Divisor copy taken at start.
    logic             dz_work;
    logic [16:0]      r_shift;
    logic [17:0]      trial;
    logic             fits;        // Divisor fits, quotient bit is one.
    logic [31:0]      q_next;
    logic [15:0]      r_next;
    logic             busy;
    logic [cnt_w-1:0] step_cnt;    // Steps left after this one.
    logic             start;
    // Results.
    logic [31:0]      quo;
    logic [15:0]      rem;
    logic             dz;          // Last division had a zero divisor.
    logic [15:0]      rd_data;

    assign start = we && (reg_sel == div_start) && !busy;  // Ignored while busy.

    // One restoring step. A zero divisor always fits, which leaves all ones
    // in the quotient and the dividend low word in the remainder.
    always_comb begin
        r_shift = {r_work, q_work[31]};
        trial   = {1'b0, r_shift} - {2'b00, d_work};
        fits    = !trial[17];
        r_next  = fits ? trial[15:0] : r_shift[15:0];
        q_next  = {q_work[30:0], fits};
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_work  <= num;
            r_work  <= '0;
            d_work  <= den;
            dz_work <= (den == '0);
        end else if (busy) begin
            q_work <= q_next;
            r_work <= r_next;
        end
    end

    always_comb begin
        case (reg_sel)
            div_num_hi: rd_data = num[31:16];
            div_num_lo: rd_data = num[15:0];
            div_den:    rd_data = den;
            div_stat:   rd_data = {14'd0, dz, busy};
            div_q_hi:   rd_data = quo[31:16];
            div_q_lo:   rd_data = quo[15:0];
            div_rem:    rd_data = rem;
            default:    rd_data = open_bus;   // Start is write only.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num      <= '0;
            den      <= '0;
            busy     <= 1'b0;
            step_cnt <= '0;
            quo      <= '0;
            rem      <= '0;
            dz       <= 1'b0;
            dout     <= '0;
        end else begin
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= cnt_w'(div_steps - 1);
            end else if (busy) begin
                step_cnt <= step_cnt - 1'b1;
                if (step_cnt == '0) begin
                    busy <= 1'b0;             // Last step lands in the results.
                    quo  <= q_next;
                    rem  <= r_next;
                    dz   <= dz_work;
                end
            end
            if (we) begin
                case (reg_sel)
                    div_num_hi: num[31:16] <= lane_merge(num[31:16], din, dsn);
                    div_num_lo: num[15:0]  <= lane_merge(num[15:0], din, dsn);
                    div_den:    den        <= lane_merge(den, din, dsn);
                    default: ;
                endcase
            end else if (cs) begin
                dout <= rd_data;
            end
        end
    end

endmodule

/* source/jts16b_math.sv */
// Top level of the arithmetic helper chips.
// Bus decoder plus multiplier, divider and compare/timer units.
module jts16b_math #(
    parameter logic [11:0] mul_base = jts16b_math_pkg::def_mul_base,
    parameter logic [11:0] div_base = jts16b_math_pkg::def_div_base,
    parameter logic [11:0] cmp_base = jts16b_math_pkg::def_cmp_base
) (
    input  logic                      clk,
    input  logic                      rst,
    input  jts16b_math_pkg::cpu_bus_t bus,
    output logic [15:0]               dout,
    output logic                      snd_irq,
    output logic [7:0]                snd_data
);

    logic        mul_cs;
    logic        div_cs;
    logic        cmp_cs;
    logic        mul_we;
    logic        div_we;
    logic        cmp_we;
    logic [3:0]  reg_sel;     // Shared by all units.
    logic [15:0] mul_dout;
    logic [15:0] div_dout;
    logic [15:0] cmp_dout;

    jts16b_bus_decode #(
        .mul_base (mul_base),
        .div_base (div_base),
        .cmp_base (cmp_base)
    ) u_decode (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .mul_dout (mul_dout),
        .div_dout (div_dout),
        .cmp_dout (cmp_dout),
        .mul_cs   (mul_cs),
        .div_cs   (div_cs),
        .cmp_cs   (cmp_cs),
        .mul_we   (mul_we),
        .div_we   (div_we),
        .cmp_we   (cmp_we),
        .reg_sel  (reg_sel),
        .dout     (dout)
    );

    jts16b_multiplier u_mul (
        .clk     (clk),
        .rst     (rst),
        .cs      (mul_cs),
        .we      (mul_we),
        .reg_sel (reg_sel),
        .dsn     (bus.dsn),
        .din     (bus.din),
        .dout    (mul_dout)
    );

    jts16b_divider u_div (
        .clk     (clk),
        .rst     (rst),
        .cs      (div_cs),
        .we      (div_we),
        .reg_sel (reg_sel),
        .dsn     (bus.dsn),
        .din     (bus.din),
        .dout    (div_dout)
    );

    jts16b_timer u_cmp (
        .clk      (clk),
        .rst      (rst),
        .cs       (cmp_cs),
        .we       (cmp_we),
        .reg_sel  (reg_sel),
        .dsn      (bus.dsn),
        .din      (bus.din),
        .dout     (cmp_dout),
        .snd_irq  (snd_irq),
        .snd_data (snd_data)
    );

endmodule

/* verification/jts16b_math_assertions.sv */
// Bound checker for the math chips.
// Shadow register models of the three units and assertions on read data and sound.
module jts16b_math_assertions #(
    parameter logic [11:0] mul_base = jts16b_math_pkg::def_mul_base,
    parameter logic [11:0] div_base = jts16b_math_pkg::def_div_base,
    parameter logic [11:0] cmp_base = jts16b_math_pkg::def_cmp_base
) (
    input logic                      clk,
    input logic                      rst,
    input jts16b_math_pkg::cpu_bus_t bus,
    input logic [15:0]               dout,
    input logic                      snd_irq,
    input logic [7:0]                snd_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import jts16b_math_pkg::*;

    logic signed [15:0] op_a, op_b, bnd1, bnd2, val, lo_b, hi_b;
    logic signed [31:0] prod;
    logic [15:0] num_hi, num_lo, den, hist, rem, rem_pend, exp_now, exp_q;
    logic [31:0] quo, quo_pend;
    logic [5:0]  cnt;                 // Divider cycles left.
    logic [3:0]  ptr, sel;
    logic [11:0] win;
    logic [7:0]  snd_d;
    logic        dz, dz_pend, busy, cmp_wr_q, snd_m, wr, rd, rd_q, in_range;
    logic        fail_seen = 1'b0;

    function automatic logic [15:0] apply_lanes(input logic [15:0] cur,
                                                input logic [15:0] new_w,
                                                input logic [1:0]  en_n);
        apply_lanes[15:8] = en_n[1] ? cur[15:8] : new_w[15:8];
        apply_lanes[7:0]  = en_n[0] ? cur[7:0]  : new_w[7:0];
    endfunction

    assign win      = bus.addr[23:12];
    assign sel      = bus.addr[4:1];
    assign wr       = bus.as && !bus.rnw && (bus.dsn != 2'b11);
    assign rd       = bus.as && !wr;
    assign busy     = (cnt != 6'd0);
    assign lo_b     = (bnd1 < bnd2) ? bnd1 : bnd2;
    assign hi_b     = (bnd1 < bnd2) ? bnd2 : bnd1;
    assign in_range = (val >= lo_b) && (val <= hi_b);
    assign prod     = op_a * op_b;

    always_comb begin
        exp_now = open_bus;                   // Unmapped by default.
        if (win == mul_base) begin
            case (sel)
                mul_a:  exp_now = op_a;
                mul_b:  exp_now = op_b;
                mul_hi: exp_now = prod[31:16];
                mul_lo: exp_now = prod[15:0];
                default: ;
            endcase
        end else if (win == div_base) begin
            case (sel)
                div_num_hi: exp_now = num_hi;
                div_num_lo: exp_now = num_lo;
                div_den:    exp_now = den;
                div_stat:   exp_now = {14'd0, dz, busy};
                div_q_hi:   exp_now = quo[31:16];
                div_q_lo:   exp_now = quo[15:0];
                div_rem:    exp_now = rem;
                default: ;
            endcase
        end else if (win == cmp_base) begin
            case (sel)
                cmp_bound1:    exp_now = bnd1;
                cmp_bound2:    exp_now = bnd2;
                cmp_value:     exp_now = val;
                cmp_value_alt: exp_now = val;
                cmp_hist:      exp_now = hist;
                cmp_stat:      exp_now = in_range ? 16'h0000 :
                                         (val < lo_b) ? 16'h8000 : 16'h4000;
                cmp_clamp:     exp_now = (val < lo_b) ? lo_b :
                                         (val > hi_b) ? hi_b : val;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {op_a, op_b, bnd1, bnd2, val, num_hi, num_lo, den} <= '0;
            {hist, rem, rem_pend, quo, quo_pend, exp_q} <= '0;
            {cnt, ptr, snd_d, dz, dz_pend, cmp_wr_q, snd_m, rd_q} <= '0;
        end else begin
            cmp_wr_q <= wr && (win == cmp_base);   // Marks a write burst.
            rd_q     <= rd;
            if (rd)
                exp_q <= exp_now;
            if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin               // Results land with busy low.
                    quo <= quo_pend;
                    rem <= rem_pend;
                    dz  <= dz_pend;
                end
            end
            if (wr && win == mul_base) begin
                if (sel == mul_a) op_a <= apply_lanes(op_a, bus.din, bus.dsn);
                if (sel == mul_b) op_b <= apply_lanes(op_b, bus.din, bus.dsn);
            end
            if (wr && win == div_base) begin
                case (sel)
                    div_num_hi: num_hi <= apply_lanes(num_hi, bus.din, bus.dsn);
                    div_num_lo: num_lo <= apply_lanes(num_lo, bus.din, bus.dsn);
                    div_den:    den    <= apply_lanes(den, bus.din, bus.dsn);
                    div_start: if (!busy) begin
                        cnt      <= 6'(div_steps);
                        dz_pend  <= (den == 16'd0);
                        quo_pend <= (den == 16'd0) ? 32'hFFFF_FFFF :
                                    {num_hi, num_lo} / {16'd0, den};
                        rem_pend <= (den == 16'd0) ? num_lo :
                                    16'({num_hi, num_lo} % {16'd0, den});
                    end
                    default: ;
                endcase
            end
            if (wr && win == cmp_base) begin
                case (sel)
                    cmp_bound1:    bnd1 <= apply_lanes(bnd1, bus.din, bus.dsn);
                    cmp_bound2:    bnd2 <= apply_lanes(bnd2, bus.din, bus.dsn);
                    cmp_value_alt: val  <= apply_lanes(val, bus.din, bus.dsn);
                    cmp_value: begin
                        val <= apply_lanes(val, bus.din, bus.dsn);
                        if (!cmp_wr_q) begin
                            hist[ptr] <= in_range;
                            ptr       <= ptr + 4'd1;
                        end
                    end
                    cmp_hist: begin
                        hist <= '0;
                        ptr  <= '0;
                    end
                    cmp_sound: begin
                        snd_d <= bus.din[7:0];
                        snd_m <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    read_data: assert property (@(posedge clk) disable iff (rst) rd_q |-> dout == exp_q)
        else begin
            fail_seen = 1'b1;
            $error("FAIL dout expected %h actual %h", $sampled(exp_q), $sampled(dout));
        end

    sound_irq: assert property (@(posedge clk) disable iff (rst) snd_irq == snd_m)
        else begin
            fail_seen = 1'b1;
            $error("FAIL snd_irq expected %h actual %h", $sampled(snd_m), $sampled(snd_irq));
        end

    sound_data: assert property (@(posedge clk) disable iff (rst) snd_data == snd_d)
        else begin
            fail_seen = 1'b1;
            $error("FAIL snd_data expected %h actual %h", $sampled(snd_d), $sampled(snd_data));
        end

    reset_outputs: assert property (@(posedge clk) rst |-> dout == 16'd0 && !snd_irq)
        else begin
            fail_seen = 1'b1;
            $error("Outputs not cleared while reset is held");
        end

endmodule

/* verification/jts16b_math_tb.sv */
// Testbench for the math chips.
// Clock, reset, bus tasks, stimulus sequences and watchdog.
module jts16b_math_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import jts16b_math_pkg::*;

    localparam int n_ops = 800;          // Bus operations, rounded up.

    logic        clk = 1'b0;
    logic        rst;
    cpu_bus_t    bus;
    logic [15:0] dout;
    logic        snd_irq;
    logic [7:0]  snd_data;
    logic [15:0] rdata;                  // Last read result.
    int          seed = 66953;
    bit          passed = 1'b0;
    bit          fail_printed = 1'b0;
    logic signed [15:0] b1, b2, v;

    jts16b_math UUT (.clk(clk), .rst(rst), .bus(bus), .dout(dout),
                     .snd_irq(snd_irq), .snd_data(snd_data));

    bind jts16b_math jts16b_math_assertions #(
        .mul_base (mul_base),
        .div_base (div_base),
        .cmp_base (cmp_base)
    ) u_chk (.*);

    always #10 clk = ~clk;               // 20 ns period.

    task automatic write_reg(input logic [11:0] base, input logic [3:0] sel,
                             input logic [15:0] data, input logic [1:0] lanes);
        @(negedge clk);
        bus.as   <= 1'b1;
        bus.addr <= {base, 7'd0, sel};
        bus.dsn  <= lanes;
        bus.rnw  <= 1'b0;
        bus.din  <= data;
        @(negedge clk);
        bus.as   <= 1'b0;                // Idle cycle ends the burst.
        bus.rnw  <= 1'b1;
    endtask

    task automatic write_pair(input logic [11:0] base, input logic [3:0] sel,
                              input logic [15:0] d0, input logic [15:0] d1);
        @(negedge clk);
        bus.as   <= 1'b1;
        bus.addr <= {base, 7'd0, sel};
        bus.dsn  <= 2'b00;
        bus.rnw  <= 1'b0;
        bus.din  <= d0;
        @(negedge clk);
        bus.din  <= d1;                  // Second beat, same burst.
        @(negedge clk);
        bus.as   <= 1'b0;
        bus.rnw  <= 1'b1;
    endtask

    task automatic read_reg(input logic [11:0] base, input logic [3:0] sel);
        @(negedge clk);
        bus.as   <= 1'b1;
        bus.addr <= {base, 7'd0, sel};
        bus.dsn  <= 2'b00;
        bus.rnw  <= 1'b1;
        @(negedge clk);
        bus.as   <= 1'b0;
        rdata     = dout;                // Valid the cycle after access.
    endtask

    task automatic wait_divider;
        int polls;
        polls = 0;
        do begin
            read_reg(def_div_base, div_stat);
            polls++;
        end while (rdata[0] && polls < div_steps + 4);
        if (rdata[0]) begin
            $display("Divider still busy after %0d polls", polls);
            fail_printed = 1'b1;
            $display("FAIL: see errors above");
            $fatal(1, "Divider timeout");
        end
    endtask

    task automatic run_division(input logic [31:0] num, input logic [15:0] den);
        write_reg(def_div_base, div_num_hi, num[31:16], 2'b00);
        write_reg(def_div_base, div_num_lo, num[15:0], 2'b00);
        write_reg(def_div_base, div_den, den, 2'b00);
        write_reg(def_div_base, div_start, 16'd0, 2'b00);
        read_reg(def_div_base, div_stat);              // Busy right after start.
        write_reg(def_div_base, div_start, 16'd0, 2'b00);  // Ignored while busy.
        wait_divider();
        read_reg(def_div_base, div_q_hi);
        read_reg(def_div_base, div_q_lo);
        read_reg(def_div_base, div_rem);
    endtask

    initial begin
        #(n_ops * (div_steps + 4) * 20);
        fail_printed = 1'b1;
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired before the tests finished");
    end

    initial begin
        bus = '0;
        bus.rnw = 1'b1;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        // Reset values of every mapped register.
        for (int s = 0; s < 4; s++) read_reg(def_mul_base, 4'(s));
        for (int s = 0; s < 8; s++) if (s != 3) read_reg(def_div_base, 4'(s));
        for (int s = 0; s < 8; s++) if (s != 5) read_reg(def_cmp_base, 4'(s));

        // Multiplier with full and single-lane writes.
        for (int i = 0; i < 40; i++) begin
            write_reg(def_mul_base, mul_a, 16'($random(seed)), 2'(i % 3));
            write_reg(def_mul_base, mul_b, 16'($random(seed)), 2'((i / 3) % 3));
            read_reg(def_mul_base, mul_hi);
            read_reg(def_mul_base, mul_lo);
            read_reg(def_mul_base, mul_a);
        end

        // Divider with random operands, then a zero divisor.
        for (int i = 0; i < 10; i++)
            run_division(32'($random(seed)), 16'($random(seed)) | 16'd1);
        run_division(32'h1234_ABCD, 16'd0);

        // Clamp with bounds in either order.
        for (int i = 0; i < 20; i++) begin
            b1 = 16'($random(seed) % 2000);
            b2 = 16'($random(seed) % 2000);
            write_reg(def_cmp_base, cmp_bound1, b1, 2'b00);
            write_reg(def_cmp_base, cmp_bound2, b2, 2'b00);
            for (int k = 0; k < 3; k++) begin
                v = (k == 0) ? -16'sd30000 : (k == 1) ? 16'((b1 + b2) / 2) : 16'sd30000;
                write_reg(def_cmp_base, cmp_value_alt, v, 2'b00);
                read_reg(def_cmp_base, cmp_clamp);
                read_reg(def_cmp_base, cmp_stat);
            end
        end

        // History, bursts, alternate value and sound latch.
        write_reg(def_cmp_base, cmp_bound1, 16'hFF00, 2'b00);
        write_reg(def_cmp_base, cmp_bound2, 16'h0100, 2'b00);
        write_reg(def_cmp_base, cmp_hist, 16'd0, 2'b00);
        for (int i = 0; i < 6; i++) begin
            v = (i % 3 == 0) ? 16'sd5000 : 16'($random(seed) % 200);
            write_reg(def_cmp_base, cmp_value, v, 2'b00);
        end
        read_reg(def_cmp_base, cmp_hist);
        write_pair(def_cmp_base, cmp_value, 16'h7000, 16'h0010);
        write_reg(def_cmp_base, cmp_value_alt, 16'h8000, 2'b00);
        write_reg(def_cmp_base, cmp_value_alt, 16'h0000, 2'b00);
        write_reg(def_cmp_base, cmp_value, 16'h0020, 2'b00);  // Shows where the pointer is.
        read_reg(def_cmp_base, cmp_hist);
        write_reg(def_cmp_base, cmp_sound, 16'hA55A, 2'b00);
        read_reg(def_cmp_base, cmp_sound);

        // Open bus outside the windows and on unused registers.
        read_reg(12'h000, 4'd0);
        read_reg(12'hC03, 4'd2);
        read_reg(def_mul_base, 4'd5);
        read_reg(def_div_base, div_start);
        read_reg(def_div_base, 4'd9);
        read_reg(def_cmp_base, 4'd5);
        read_reg(def_cmp_base, 4'd12);
        repeat (2) @(negedge clk);

        if (UUT.u_chk.fail_seen) begin
            fail_printed = 1'b1;
            $display("FAIL: see errors above");
            $fatal(1, "Assertion failures seen");
        end else begin
            passed = 1'b1;
            $display("PASS: all tests");
            $finish;
        end
    end

    final begin
        if (!passed && !fail_printed)
            $display("FAIL: see errors above");
    end

endmodule

/* jts16b_math.f */
common/jts16b_math_pkg.sv
source/jts16b_bus_decode.sv
source/jts16b_multiplier.sv
compare/jts16b_timer.sv
divide/jts16b_divider.sv
source/jts16b_math.sv
verification/jts16b_math_assertions.sv
verification/jts16b_math_tb.sv

/* Makefile */
TOP = jts16b_math_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f jts16b_math.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f jts16b_math.f --top-module $(TOP) \
		-Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1 | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
